// ==== Bender.yml ====
package:
  name: huff_front

sources:
  - verilog/huff_cfg_pkg.sv
  - verilog/huff_phase_pkg.sv
  - verilog/phase_controller.sv
  - verilog/byte_packer.sv
  - verilog/histogram.sv
  - verilog/least_value_finder.sv
  - verilog/huff_front_top.sv
  - target: test
    files:
      - verification/huff_front_chk.sv
      - verification/huff_front_tb.sv

// ==== src.f ====
verilog/huff_cfg_pkg.sv
verilog/huff_phase_pkg.sv
verilog/phase_controller.sv
verilog/byte_packer.sv
verilog/histogram.sv
verilog/least_value_finder.sv
verilog/huff_front_top.sv
verification/huff_front_chk.sv
verification/huff_front_tb.sv

// ==== verification/huff_front_chk.sv ====
`default_nettype none

module huff_front_chk (
  input logic                               hwclk,
  input logic                               reset_i,
  input logic                               finished_o,
  input logic                               out_of_init_o,
  input logic [huff_phase_pkg::phase_w-1:0] phase_o
);
  import huff_phase_pkg::*;

  int fail_count = 0;

  // idle -> clear -> count -> scan -> done -> clear
  function automatic logic legal_step(input logic [phase_w-1:0] prev,
                                      input logic [phase_w-1:0] cur);
    case (prev)
      ph_idle:  return (cur == ph_idle) || (cur == ph_clear);
      ph_clear: return (cur == ph_clear) || (cur == ph_count);
      ph_count: return (cur == ph_count) || (cur == ph_scan);
      ph_scan:  return (cur == ph_scan) || (cur == ph_done);
      ph_done:  return (cur == ph_done) || (cur == ph_clear);
      default:  return 1'b0;
    endcase
  endfunction

  finished_in_done: assert property (@(posedge hwclk) disable iff (reset_i)
    finished_o |-> (phase_o == ph_done))
    else begin
      $error("finished_o high while phase is %0d", phase_o);
      fail_count++;
    end

  init_in_count: assert property (@(posedge hwclk) disable iff (reset_i)
    out_of_init_o |-> (phase_o == ph_count))
    else begin
      $error("out_of_init_o high while phase is %0d", phase_o);
      fail_count++;
    end

  phase_order: assert property (@(posedge hwclk) disable iff (reset_i)
    legal_step($past(phase_o), phase_o))
    else begin
      $error("illegal phase step from %0d to %0d", $past(phase_o), phase_o);
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== verification/huff_front_tb.sv ====
`default_nettype none

module huff_front_tb;
  import huff_cfg_pkg::*;
  import huff_phase_pkg::*;

  localparam int n_rows = 8;

  logic                 hwclk;
  logic                 reset_i;
  logic                 start_i;
  logic                 chunk_valid_i;
  logic [chunk_w-1:0]   chunk_i;
  logic                 finished_o;
  logic                 out_of_init_o;
  logic [phase_w-1:0]   phase_o;
  logic [2:0]           leftover_count_o;
  logic [count_w-1:0]   total_o;
  logic [byte_w-1:0]    least1_idx_o;
  logic [byte_w-1:0]    least2_idx_o;
  logic [count_w-1:0]   least1_count_o;
  logic [count_w-1:0]   least2_count_o;
  logic [sum_w-1:0]     sum_o;
  logic [1:0]           found_o;

  // one run per row, fixed bytes listed low byte first
  // seven_bytes is six bytes plus eof, exactly eight chunks
  string       row_name  [n_rows] = '{"eof_only", "single_byte", "repeated", "seven_bytes",
                                      "tie_rule", "random_long", "rerun_small", "random_mid"};
  int          row_len   [n_rows] = '{0, 1, 4, 6, 8, 40, 2, 24};
  bit          row_rand  [n_rows] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
  logic [63:0] row_bytes [n_rows] = '{64'h0, 64'h41, 64'h4141_4141, 64'h0000_0530_3020_2010,
                                      64'h9999_0707_42c3_42c3, 64'h0, 64'h6655, 64'h0};

  int model_count [table_depth];
  int fail_checks;
  int tests_passed;
  int tests_failed;
  int cycle_count;

  huff_front_top dut0 (
    .hwclk            (hwclk),
    .reset_i          (reset_i),
    .start_i          (start_i),
    .chunk_valid_i    (chunk_valid_i),
    .chunk_i          (chunk_i),
    .finished_o       (finished_o),
    .out_of_init_o    (out_of_init_o),
    .phase_o          (phase_o),
    .leftover_count_o (leftover_count_o),
    .total_o          (total_o),
    .least1_idx_o     (least1_idx_o),
    .least2_idx_o     (least2_idx_o),
    .least1_count_o   (least1_count_o),
    .least2_count_o   (least2_count_o),
    .sum_o            (sum_o),
    .found_o          (found_o)
  );

  bind huff_front_top huff_front_chk chk0 (
    .hwclk         (hwclk),
    .reset_i       (reset_i),
    .finished_o    (finished_o),
    .out_of_init_o (out_of_init_o),
    .phase_o       (phase_o)
  );

  initial begin
    hwclk = 1'b0;
    forever #4 hwclk = ~hwclk;
  end

  task automatic check_value(input string test, input string what, input int expected,
                             input int actual);
    assert (actual == expected) else begin
      $display("ERROR %s %s expected %0d actual %0d", test, what, expected, actual);
      fail_checks++;
    end
  endtask

  task automatic report_test(input string test, input int errs_before);
    if (fail_checks == errs_before) begin
      tests_passed++;
      $display("test %s ok", test);
    end else begin
      tests_failed++;
      $display("test %s had %0d mismatches", test, fail_checks - errs_before);
    end
  endtask

  task automatic pulse_start();
    @(posedge hwclk);
    start_i <= 1'b1;
    @(posedge hwclk);
    start_i <= 1'b0;
  endtask

  task automatic wait_for_init();
    @(posedge hwclk);
    while (!out_of_init_o) begin
      @(posedge hwclk);
    end
  endtask

  task automatic wait_for_finished();
    @(posedge hwclk);
    while (!finished_o) begin
      @(posedge hwclk);
    end
  endtask

  // two smallest non-zero counts, ordered by count then by index
  task automatic pick_least(output int l1i, output int l1c, output int l2i, output int l2c,
                            output int found);
    int i;
    found = 0;
    l1i   = 0;
    l1c   = 0;
    l2i   = 0;
    l2c   = 0;
    for (i = 0; i < table_depth; i++) begin
      if (model_count[i] != 0) begin
        found++;
        if (l1c == 0 || model_count[i] < l1c) begin
          l1i = i;
          l1c = model_count[i];
        end
      end
    end
    for (i = 0; i < table_depth; i++) begin
      if (i != l1i && model_count[i] != 0 && (l2c == 0 || model_count[i] < l2c)) begin
        l2i = i;
        l2c = model_count[i];
      end
    end
    if (found > 2) begin
      found = 2;
    end
  endtask

  task automatic run_row(input int r);
    logic [7:0]         stream [$];
    logic [7:0]         b;
    logic [chunk_w-1:0] chunk;
    int                 i;
    int                 c;
    int                 j;
    int                 nbits;
    int                 nchunks;
    int                 bit_idx;
    int                 l1i;
    int                 l1c;
    int                 l2i;
    int                 l2c;
    int                 found;
    int                 errs_before;
    errs_before = fail_checks;
    for (i = 0; i < table_depth; i++) begin
      model_count[i] = 0;
    end
    for (i = 0; i < row_len[r]; i++) begin
      if (row_rand[r]) begin
        // narrow range so repeated values and ties show up
        b = 8'($urandom_range(0, 63));
        while (b == eof_code) begin
          b = 8'($urandom_range(0, 63));
        end
      end else begin
        b = row_bytes[r][8*i +: 8];
      end
      stream.push_back(b);
      model_count[b]++;
    end
    stream.push_back(eof_code);
    nbits   = 8 * stream.size();
    nchunks = (nbits + 6) / 7;
    pulse_start();
    wait_for_init();
    // bit 0 of the first byte goes out first, tail padded with zeros
    for (c = 0; c < nchunks; c++) begin
      for (j = 0; j < 7; j++) begin
        bit_idx = c * 7 + j;
        if (bit_idx < nbits) begin
          b        = stream[bit_idx / 8];
          chunk[j] = b[bit_idx % 8];
        end else begin
          chunk[j] = 1'b0;
        end
      end
      chunk_valid_i <= 1'b1;
      chunk_i       <= chunk;
      @(posedge hwclk);
    end
    chunk_valid_i <= 1'b0;
    chunk_i       <= '0;
    wait_for_finished();
    pick_least(l1i, l1c, l2i, l2c, found);
    check_value(row_name[r], "phase_o", int'(ph_done), phase_o);
    check_value(row_name[r], "total_o", row_len[r], total_o);
    check_value(row_name[r], "found_o", found, found_o);
    check_value(row_name[r], "least1_idx_o", l1i, least1_idx_o);
    check_value(row_name[r], "least1_count_o", l1c, least1_count_o);
    check_value(row_name[r], "least2_idx_o", l2i, least2_idx_o);
    check_value(row_name[r], "least2_count_o", l2c, least2_count_o);
    check_value(row_name[r], "sum_o", l1c + l2c, sum_o);
    check_value(row_name[r], "leftover_count_o", (7 * nchunks) % 8, leftover_count_o);
    report_test(row_name[r], errs_before);
  endtask

  // run limit scales with the table walks and the stream length of every row
  initial begin : watchdog
    int limit;
    int r;
    limit       = 0;
    cycle_count = 0;
    for (r = 0; r < n_rows; r++) begin
      limit += 2 * table_depth + 2 * row_len[r] + 50;
    end
    limit = 2 * limit;
    while (cycle_count < limit) begin
      @(posedge hwclk);
      cycle_count++;
    end
    $display("run stopped after %0d cycles, the DUT never reached finished_o", cycle_count);
    $display("Testbench failed");
    $finish;
  end

  initial begin : main
    int r;
    int errs_before;
    void'($urandom(32'hf9b457f9));
    fail_checks   = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    reset_i       = 1'b1;
    start_i       = 1'b0;
    chunk_valid_i = 1'b0;
    chunk_i       = '0;
    repeat (16) @(posedge hwclk);
    reset_i <= 1'b0;
    @(posedge hwclk);
    errs_before = fail_checks;
    check_value("reset_state", "finished_o", 0, finished_o);
    check_value("reset_state", "out_of_init_o", 0, out_of_init_o);
    check_value("reset_state", "phase_o", int'(ph_idle), phase_o);
    report_test("reset_state", errs_before);
    for (r = 0; r < n_rows; r++) begin
      run_row(r);
    end
    $display("%0d tests, %0d passed, %0d failed, %0d failed checks, %0d assertion failures",
             tests_passed + tests_failed, tests_passed, tests_failed, fail_checks,
             dut0.chk0.fail_count);
    if (fail_checks == 0 && dut0.chk0.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/byte_packer.sv ====
`default_nettype none

module byte_packer (
  input  logic                             hwclk,
  input  logic                             reset_i,
  input  huff_phase_pkg::phase_t           phase_i,
  input  logic                             chunk_valid_i,
  input  logic [huff_cfg_pkg::chunk_w-1:0] chunk_i,
  output logic                             byte_valid_o,
  output logic [huff_cfg_pkg::byte_w-1:0]  byte_o,
  output logic [2:0]                       leftover_count_o
);
  import huff_cfg_pkg::*;
  import huff_phase_pkg::*;

  // leftover bits, right aligned, bits above cnt_q held at zero
  logic [chunk_w-1:0]   acc_q;
  logic [2:0]           cnt_q;
  logic [2*chunk_w-1:0] merged;
  logic [3:0]           fill;

  // new chunk lands just above the bits already held
  always_comb begin
    merged = {{chunk_w{1'b0}}, acc_q} | ({{chunk_w{1'b0}}, chunk_i} << cnt_q);
    fill   = {1'b0, cnt_q} + 4'(chunk_w);
  end

  // a byte is ready as soon as eight bits are available
  assign byte_valid_o     = chunk_valid_i & fill[3];
  assign byte_o           = merged[byte_w-1:0];
  assign leftover_count_o = cnt_q;

  always_ff @(posedge hwclk) begin
    if (reset_i || phase_i == ph_clear) begin
      acc_q <= '0;
      cnt_q <= '0;
    end else if (chunk_valid_i) begin
      if (fill[3]) begin
        // low byte leaves, the rest shifts down
        acc_q <= {1'b0, merged[2*chunk_w-1:byte_w]};
        cnt_q <= fill[2:0];
      end else begin
        acc_q <= merged[chunk_w-1:0];
        cnt_q <= fill[2:0];
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/histogram.sv ====
`default_nettype none

module histogram (
  input  logic                             hwclk,
  input  logic                             reset_i,
  input  huff_phase_pkg::phase_t           phase_i,
  input  logic                             byte_valid_i,
  input  logic [huff_cfg_pkg::byte_w-1:0]  byte_i,
  input  logic [huff_cfg_pkg::byte_w-1:0]  scan_addr_i,
  output logic [huff_cfg_pkg::count_w-1:0] scan_count_o,
  output logic [huff_cfg_pkg::count_w-1:0] total_o,
  output logic                             clear_done_o,
  output logic                             eof_seen_o,
  output logic                             out_of_init_o
);
  import huff_cfg_pkg::*;
  import huff_phase_pkg::*;

  logic [count_w-1:0] count_q [table_depth];
  logic [byte_w-1:0]  clr_ptr_q;
  logic [count_w-1:0] hit_count;
  logic               count_en;
  logic               is_eof;
  logic               add_byte;

  // bytes after the eof marker are ignored until the phase moves on
  assign count_en  = byte_valid_i && (phase_i == ph_count) && !eof_seen_o;
  assign is_eof    = (byte_i == eof_code);
  assign add_byte  = count_en && !is_eof;
  assign hit_count = count_q[byte_i];

  // last entry of the clear walk
  assign clear_done_o  = (phase_i == ph_clear) && (clr_ptr_q == byte_w'(table_depth - 1));
  assign out_of_init_o = (phase_i == ph_count);

  // read port for the least value scan, same cycle
  assign scan_count_o = count_q[scan_addr_i];

  always_ff @(posedge hwclk) begin
    if (reset_i || phase_i != ph_clear) begin
      clr_ptr_q <= '0;
    end else begin
      clr_ptr_q <= clr_ptr_q + 1'b1;
    end
  end

  // one entry zeroed per clear cycle, otherwise increment on a hit
  always_ff @(posedge hwclk) begin
    if (phase_i == ph_clear) begin
      count_q[clr_ptr_q] <= '0;
    end else if (add_byte && hit_count != '1) begin
      count_q[byte_i] <= hit_count + 1'b1;
    end
  end

  always_ff @(posedge hwclk) begin
    if (reset_i) begin
      total_o    <= '0;
      eof_seen_o <= 1'b0;
    end else begin
      eof_seen_o <= count_en && is_eof;
      if (phase_i == ph_clear) begin
        total_o <= '0;
      end else if (add_byte && total_o != '1) begin
        // saturate rather than wrap
        total_o <= total_o + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/huff_cfg_pkg.sv ====
`default_nettype none

package huff_cfg_pkg;

  // incoming chunk width, one character per pulse
  localparam int unsigned chunk_w = 7;

  // assembled byte and histogram index
  localparam int unsigned byte_w = 8;

  // one entry per byte value
  localparam int unsigned table_depth = 256;

  // per-entry count and running total
  localparam int unsigned count_w = 16;

  // room for the carry when the two least counts are added
  localparam int unsigned sum_w = count_w + 1;

  // end of file marker, never counted
  localparam logic [byte_w-1:0] eof_code = 8'h1A;

endpackage

`default_nettype wire

// ==== verilog/huff_front_top.sv ====
`default_nettype none

module huff_front_top (
  input  logic                                  hwclk,
  input  logic                                  reset_i,
  input  logic                                  start_i,
  input  logic                                  chunk_valid_i,
  input  logic [huff_cfg_pkg::chunk_w-1:0]      chunk_i,
  output logic                                  finished_o,
  output logic                                  out_of_init_o,
  output logic [huff_phase_pkg::phase_w-1:0]    phase_o,
  output logic [2:0]                            leftover_count_o,
  output logic [huff_cfg_pkg::count_w-1:0]      total_o,
  output logic [huff_cfg_pkg::byte_w-1:0]       least1_idx_o,
  output logic [huff_cfg_pkg::byte_w-1:0]       least2_idx_o,
  output logic [huff_cfg_pkg::count_w-1:0]      least1_count_o,
  output logic [huff_cfg_pkg::count_w-1:0]      least2_count_o,
  output logic [huff_cfg_pkg::sum_w-1:0]        sum_o,
  output logic [1:0]                            found_o
);
  import huff_cfg_pkg::*;
  import huff_phase_pkg::*;

  phase_t             phase;
  logic               clear_done;
  logic               eof_seen;
  logic               scan_done;
  logic               byte_valid;
  logic [byte_w-1:0]  byte_data;
  logic [byte_w-1:0]  scan_addr;
  logic [count_w-1:0] scan_count;

  assign phase_o = phase;

  phase_controller controller (
    .hwclk        (hwclk),
    .reset_i      (reset_i),
    .start_i      (start_i),
    .clear_done_i (clear_done),
    .eof_seen_i   (eof_seen),
    .scan_done_i  (scan_done),
    .phase_o      (phase),
    .finished_o   (finished_o)
  );

  byte_packer packer (
    .hwclk            (hwclk),
    .reset_i          (reset_i),
    .phase_i          (phase),
    .chunk_valid_i    (chunk_valid_i),
    .chunk_i          (chunk_i),
    .byte_valid_o     (byte_valid),
    .byte_o           (byte_data),
    .leftover_count_o (leftover_count_o)
  );

  histogram hist (
    .hwclk         (hwclk),
    .reset_i       (reset_i),
    .phase_i       (phase),
    .byte_valid_i  (byte_valid),
    .byte_i        (byte_data),
    .scan_addr_i   (scan_addr),
    .scan_count_o  (scan_count),
    .total_o       (total_o),
    .clear_done_o  (clear_done),
    .eof_seen_o    (eof_seen),
    .out_of_init_o (out_of_init_o)
  );

  least_value_finder flv (
    .hwclk          (hwclk),
    .reset_i        (reset_i),
    .phase_i        (phase),
    .scan_count_i   (scan_count),
    .scan_addr_o    (scan_addr),
    .least1_idx_o   (least1_idx_o),
    .least2_idx_o   (least2_idx_o),
    .least1_count_o (least1_count_o),
    .least2_count_o (least2_count_o),
    .sum_o          (sum_o),
    .found_o        (found_o),
    .scan_done_o    (scan_done)
  );

endmodule

`default_nettype wire

// ==== verilog/huff_phase_pkg.sv ====
`default_nettype none

package huff_phase_pkg;

  localparam int unsigned phase_w = 3;

  // controller phases in the order they are visited
  // idle -> clear -> count -> scan -> done -> clear ...
  typedef enum logic [phase_w-1:0] {
    ph_idle  = 3'd0,
    ph_clear = 3'd1,
    ph_count = 3'd2,
    ph_scan  = 3'd3,
    ph_done  = 3'd4
  } phase_t;

endpackage

`default_nettype wire

// ==== verilog/least_value_finder.sv ====
`default_nettype none

module least_value_finder (
  input  logic                             hwclk,
  input  logic                             reset_i,
  input  huff_phase_pkg::phase_t           phase_i,
  input  logic [huff_cfg_pkg::count_w-1:0] scan_count_i,
  output logic [huff_cfg_pkg::byte_w-1:0]  scan_addr_o,
  output logic [huff_cfg_pkg::byte_w-1:0]  least1_idx_o,
  output logic [huff_cfg_pkg::byte_w-1:0]  least2_idx_o,
  output logic [huff_cfg_pkg::count_w-1:0] least1_count_o,
  output logic [huff_cfg_pkg::count_w-1:0] least2_count_o,
  output logic [huff_cfg_pkg::sum_w-1:0]   sum_o,
  output logic [1:0]                       found_o,
  output logic                             scan_done_o
);
  import huff_cfg_pkg::*;
  import huff_phase_pkg::*;

  // one extra bit so the walk can sit one past the last index
  logic [byte_w:0] step_q;
  logic            scanning;
  logic            hit;
  logic            below1;
  logic            below2;

  assign scan_addr_o = step_q[byte_w-1:0];
  assign scanning    = (phase_i == ph_scan) && (step_q < table_depth);
  assign scan_done_o = (phase_i == ph_scan) && (step_q == table_depth);

  // zero entries are not characters of the file
  assign hit = scanning && (scan_count_i != '0);

  // strict compares, an equal count at a later index never wins
  assign below1 = (found_o == 2'd0) || (scan_count_i < least1_count_o);
  assign below2 = (found_o != 2'd2) || (scan_count_i < least2_count_o);

  assign sum_o = sum_w'(least1_count_o) + sum_w'(least2_count_o);

  always_ff @(posedge hwclk) begin
    if (reset_i || phase_i != ph_scan) begin
      step_q <= '0;
    end else if (scanning) begin
      step_q <= step_q + 1'b1;
    end
  end

  // results stay put after the scan until the next clear
  always_ff @(posedge hwclk) begin
    if (reset_i || phase_i == ph_clear) begin
      least1_idx_o   <= '0;
      least2_idx_o   <= '0;
      least1_count_o <= '0;
      least2_count_o <= '0;
      found_o        <= '0;
    end else if (hit) begin
      if (found_o != 2'd2) begin
        found_o <= found_o + 1'b1;
      end
      if (below1) begin
        // previous smallest drops to second place
        least2_idx_o   <= least1_idx_o;
        least2_count_o <= least1_count_o;
        least1_idx_o   <= scan_addr_o;
        least1_count_o <= scan_count_i;
      end else if (below2) begin
        least2_idx_o   <= scan_addr_o;
        least2_count_o <= scan_count_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/phase_controller.sv ====
`default_nettype none

module phase_controller (
  input  logic                   hwclk,
  input  logic                   reset_i,
  input  logic                   start_i,
  input  logic                   clear_done_i,
  input  logic                   eof_seen_i,
  input  logic                   scan_done_i,
  output huff_phase_pkg::phase_t phase_o,
  output logic                   finished_o
);
  import huff_phase_pkg::*;

  phase_t phase_d;

  always_comb begin
    phase_d = phase_o;
    case (phase_o)
      // start is only honoured when no run is in flight
      ph_idle, ph_done: begin
        if (start_i) begin
          phase_d = ph_clear;
        end
      end
      ph_clear: begin
        if (clear_done_i) begin
          phase_d = ph_count;
        end
      end
      ph_count: begin
        if (eof_seen_i) begin
          phase_d = ph_scan;
        end
      end
      ph_scan: begin
        if (scan_done_i) begin
          phase_d = ph_done;
        end
      end
      default: begin
        phase_d = ph_idle;
      end
    endcase
  end

  // finished follows the next phase so it lines up with ph_done exactly
  always_ff @(posedge hwclk) begin
    if (reset_i) begin
      phase_o    <= ph_idle;
      finished_o <= 1'b0;
    end else begin
      phase_o    <= phase_d;
      finished_o <= (phase_d == ph_done);
    end
  end

endmodule

`default_nettype wire
